/* v_arch_pkg.sv */
`default_nettype none

package v_arch_pkg;

    ////////////////////////////////////////////////////////////
    // machine sizes
    ////////////////////////////////////////////////////////////
    localparam int VLEN          = 128;
    localparam int NUM_VREGS     = 32;
    localparam int DMEM_ADDR_LSB = 4;    // one 16-byte word per address

    typedef logic [31:0]     word_t;
    typedef logic [VLEN-1:0] vreg_t;
    typedef logic [4:0]      vreg_addr_t;
    typedef logic [4:0]      xreg_addr_t;
    typedef logic [4:0]      vl_t;       // 0..16 elements
    typedef logic [2:0]      sew_t;
    typedef logic [9:0]      dmem_addr_t;

    // vsew codes as in vtype
    localparam sew_t SEW_8  = 3'd0;
    localparam sew_t SEW_16 = 3'd1;
    localparam sew_t SEW_32 = 3'd2;

endpackage

`default_nettype wire

/* v_isa_pkg.sv */
`default_nettype none

package v_isa_pkg;

    // major opcodes
    localparam logic [6:0] OPC_OP_V     = 7'b1010111;
    localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
    localparam logic [6:0] OPC_STORE_FP = 7'b0100111;

    // funct3 on OP-V
    localparam logic [2:0] F3_OPIVV = 3'b000;
    localparam logic [2:0] F3_OPIVX = 3'b100;
    localparam logic [2:0] F3_OPIVI = 3'b011;
    localparam logic [2:0] F3_OPCFG = 3'b111;

    // width field of vle/vse
    localparam logic [2:0] F3_VMEM8  = 3'b000;
    localparam logic [2:0] F3_VMEM16 = 3'b101;
    localparam logic [2:0] F3_VMEM32 = 3'b110;

    localparam logic [5:0] F6_VADD = 6'b000000;
    localparam logic [5:0] F6_VSUB = 6'b000010;
    localparam logic [5:0] F6_VAND = 6'b001001;
    localparam logic [5:0] F6_VOR  = 6'b001010;
    localparam logic [5:0] F6_VXOR = 6'b001011;
    localparam logic [5:0] F6_VSLL = 6'b100101;
    localparam logic [5:0] F6_VSRL = 6'b101000;

    typedef logic [2:0] alu_op_t;
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    localparam alu_op_t ALU_SLL = 3'd5;
    localparam alu_op_t ALU_SRL = 3'd6;

    typedef logic [1:0] src_sel_t;
    localparam src_sel_t SRC_VREG = 2'd0;
    localparam src_sel_t SRC_XREG = 2'd1;
    localparam src_sel_t SRC_IMM  = 2'd2;

    typedef logic [1:0] unit_t;
    localparam unit_t UNIT_NONE  = 2'd0;
    localparam unit_t UNIT_ALU   = 2'd1;
    localparam unit_t UNIT_LOAD  = 2'd2;
    localparam unit_t UNIT_STORE = 2'd3;

endpackage

`default_nettype wire

/* v_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module v_decoder (
    input  v_arch_pkg::word_t      instr,
    output v_isa_pkg::unit_t       unit,
    output v_isa_pkg::alu_op_t     alu_op,
    output v_isa_pkg::src_sel_t    src_a_sel,
    output logic                   is_vconfig,
    output v_arch_pkg::vreg_addr_t vs1,
    output v_arch_pkg::vreg_addr_t vs2,
    output v_arch_pkg::vreg_addr_t vd,
    output logic [4:0]             imm,
    output v_arch_pkg::sew_t       zimm_sew,
    output v_arch_pkg::xreg_addr_t rs1
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [5:0] funct6;
    logic       alu_known;
    logic       unit_stride;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct6   = instr[31:26];
    assign vd       = instr[11:7];    // vs3 on stores
    assign vs1      = instr[19:15];
    assign rs1      = instr[19:15];
    assign imm      = instr[19:15];
    assign vs2      = instr[24:20];
    assign zimm_sew = instr[25:23];

    // nf, mew, mop and lumop all zero, element width one of ours
    assign unit_stride = (instr[31:26] == 6'b0) && (instr[24:20] == 5'b0) &&
                         ((funct3 == v_isa_pkg::F3_VMEM8) ||
                          (funct3 == v_isa_pkg::F3_VMEM16) ||
                          (funct3 == v_isa_pkg::F3_VMEM32));

    always_comb begin
        alu_known = 1'b1;
        case (funct6)
            v_isa_pkg::F6_VADD: alu_op = v_isa_pkg::ALU_ADD;
            v_isa_pkg::F6_VSUB: alu_op = v_isa_pkg::ALU_SUB;
            v_isa_pkg::F6_VAND: alu_op = v_isa_pkg::ALU_AND;
            v_isa_pkg::F6_VOR:  alu_op = v_isa_pkg::ALU_OR;
            v_isa_pkg::F6_VXOR: alu_op = v_isa_pkg::ALU_XOR;
            v_isa_pkg::F6_VSLL: alu_op = v_isa_pkg::ALU_SLL;
            v_isa_pkg::F6_VSRL: alu_op = v_isa_pkg::ALU_SRL;
            default: begin
                alu_op    = v_isa_pkg::ALU_ADD;
                alu_known = 1'b0;
            end
        endcase
    end

    always_comb begin
        unit       = v_isa_pkg::UNIT_NONE;
        src_a_sel  = v_isa_pkg::SRC_VREG;
        is_vconfig = 1'b0;
        case (opcode)
            v_isa_pkg::OPC_OP_V: begin
                case (funct3)
                    v_isa_pkg::F3_OPIVV: if (alu_known) unit = v_isa_pkg::UNIT_ALU;
                    v_isa_pkg::F3_OPIVX: begin
                        src_a_sel = v_isa_pkg::SRC_XREG;
                        if (alu_known) unit = v_isa_pkg::UNIT_ALU;
                    end
                    v_isa_pkg::F3_OPIVI: begin
                        src_a_sel = v_isa_pkg::SRC_IMM;
                        if (alu_known && alu_op != v_isa_pkg::ALU_SUB) begin
                            unit = v_isa_pkg::UNIT_ALU;    // no vsub.vi
                        end
                    end
                    v_isa_pkg::F3_OPCFG: is_vconfig = ~instr[31];    // vsetvli only
                    default: ;
                endcase
            end
            v_isa_pkg::OPC_LOAD_FP:  if (unit_stride) unit = v_isa_pkg::UNIT_LOAD;
            v_isa_pkg::OPC_STORE_FP: if (unit_stride) unit = v_isa_pkg::UNIT_STORE;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* vcsr.sv */
`timescale 1ns/1ps
`default_nettype none

module vcsr (
    input  logic              clk,
    input  logic              reset,
    input  logic              is_vconfig,
    input  v_arch_pkg::word_t avl,
    input  v_arch_pkg::sew_t  new_sew,
    output v_arch_pkg::vl_t   vl,
    output v_arch_pkg::sew_t  vsew
);

    v_arch_pkg::word_t vlmax;
    logic              sew_ok;

    assign sew_ok = (new_sew == v_arch_pkg::SEW_8) || (new_sew == v_arch_pkg::SEW_16) ||
                    (new_sew == v_arch_pkg::SEW_32);
    assign vlmax  = v_arch_pkg::word_t'(v_arch_pkg::VLEN / 8) >> new_sew;    // VLEN / SEW

    always_ff @(posedge clk) begin
        if (reset) begin
            vl   <= '0;
            vsew <= v_arch_pkg::SEW_8;
        end else if (is_vconfig && sew_ok) begin
            vl   <= (avl < vlmax) ? v_arch_pkg::vl_t'(avl) : v_arch_pkg::vl_t'(vlmax);
            vsew <= new_sew;
        end
    end

endmodule

`default_nettype wire

/* v_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module v_regfile (
    input  logic                   clk,
    input  logic                   reset,
    input  v_arch_pkg::vreg_addr_t rd_addr_a,
    input  v_arch_pkg::vreg_addr_t rd_addr_b,
    input  v_arch_pkg::vreg_addr_t rd_addr_c,
    input  logic                   wr_en,
    input  v_arch_pkg::vreg_addr_t wr_addr,
    input  v_arch_pkg::vreg_t      wr_data,
    output v_arch_pkg::vreg_t      rd_data_a,
    output v_arch_pkg::vreg_t      rd_data_b,
    output v_arch_pkg::vreg_t      rd_data_c
);

    v_arch_pkg::vreg_t regs [v_arch_pkg::NUM_VREGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < v_arch_pkg::NUM_VREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // combinational reads, forwarding sits outside
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];
    assign rd_data_c = regs[rd_addr_c];

endmodule

`default_nettype wire

/* v_operand_select.sv */
`timescale 1ns/1ps
`default_nettype none

module v_operand_select (
    input  v_isa_pkg::src_sel_t    src_a_sel,
    input  v_arch_pkg::vreg_t      vreg_a,
    input  v_arch_pkg::vreg_t      vreg_b,
    input  v_arch_pkg::vreg_t      vreg_old,
    input  v_arch_pkg::vreg_addr_t vs1,
    input  v_arch_pkg::vreg_addr_t vs2,
    input  v_arch_pkg::vreg_addr_t vd,
    input  v_arch_pkg::word_t      xreg,
    input  logic [4:0]             imm,
    input  v_arch_pkg::sew_t       vsew,
    input  logic                   wb_en,
    input  v_arch_pkg::vreg_addr_t wb_addr,
    input  v_arch_pkg::vreg_t      wb_data,
    output v_arch_pkg::vreg_t      op_a,
    output v_arch_pkg::vreg_t      op_b,
    output v_arch_pkg::vreg_t      old_vd
);

    localparam int VLEN = v_arch_pkg::VLEN;

    v_arch_pkg::vreg_t fwd_a;

    ////////////////////////////////////////////////////////////
    // write-back forwarding
    ////////////////////////////////////////////////////////////
    assign fwd_a  = (wb_en && wb_addr == vs1) ? wb_data : vreg_a;
    assign op_b   = (wb_en && wb_addr == vs2) ? wb_data : vreg_b;
    assign old_vd = (wb_en && wb_addr == vd) ? wb_data : vreg_old;    // also the store data

    // low SEW bits repeated over the register
    function automatic v_arch_pkg::vreg_t splat(input v_arch_pkg::word_t val,
                                                input v_arch_pkg::sew_t sew);
        case (sew)
            v_arch_pkg::SEW_8:  return {(VLEN / 8){val[7:0]}};
            v_arch_pkg::SEW_16: return {(VLEN / 16){val[15:0]}};
            default:            return {(VLEN / 32){val}};
        endcase
    endfunction

    always_comb begin
        case (src_a_sel)
            v_isa_pkg::SRC_XREG: op_a = splat(xreg, vsew);
            v_isa_pkg::SRC_IMM:  op_a = splat(v_arch_pkg::word_t'(imm), vsew);    // zero-ext
            default:             op_a = fwd_a;
        endcase
    end

endmodule

`default_nettype wire

/* v_lanes.sv */
`timescale 1ns/1ps
`default_nettype none

module v_lanes (
    input  v_isa_pkg::alu_op_t alu_op,
    input  v_arch_pkg::sew_t   sew,
    input  v_arch_pkg::vreg_t  op_a,
    input  v_arch_pkg::vreg_t  op_b,
    output v_arch_pkg::vreg_t  result
);

    localparam int VLEN = v_arch_pkg::VLEN;

    v_arch_pkg::vreg_t res_w [3];    // one result per element width

    for (genvar g = 0; g < 3; g++) begin : g_sew
        localparam int EW  = 8 << g;
        localparam int SHW = 3 + g;    // log2(EW)

        for (genvar e = 0; e < VLEN / EW; e++) begin : g_el
            logic [EW-1:0] a;
            logic [EW-1:0] b;
            logic [EW-1:0] r;

            assign a = op_a[e*EW +: EW];
            assign b = op_b[e*EW +: EW];

            always_comb begin
                case (alu_op)
                    v_isa_pkg::ALU_SUB: r = b - a;
                    v_isa_pkg::ALU_AND: r = b & a;
                    v_isa_pkg::ALU_OR:  r = b | a;
                    v_isa_pkg::ALU_XOR: r = b ^ a;
                    v_isa_pkg::ALU_SLL: r = b << a[SHW-1:0];
                    v_isa_pkg::ALU_SRL: r = b >> a[SHW-1:0];
                    default:            r = b + a;
                endcase
            end

            assign res_w[g][e*EW +: EW] = r;
        end
    end

    always_comb begin
        case (sew)
            v_arch_pkg::SEW_16: result = res_w[1];
            v_arch_pkg::SEW_32: result = res_w[2];
            default:            result = res_w[0];
        endcase
    end

endmodule

`default_nettype wire

/* v_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module v_sequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  v_isa_pkg::unit_t       unit,
    input  v_isa_pkg::alu_op_t     alu_op,
    input  v_arch_pkg::sew_t       vsew,
    input  v_arch_pkg::vl_t        vl,
    input  v_arch_pkg::vreg_addr_t vd,
    input  v_arch_pkg::vreg_t      op_a,
    input  v_arch_pkg::vreg_t      op_b,
    input  v_arch_pkg::vreg_t      old_vd,
    input  v_arch_pkg::dmem_addr_t mem_addr,
    input  v_arch_pkg::vreg_t      alu_result,
    input  v_arch_pkg::vreg_t      v_load_data,
    output v_isa_pkg::alu_op_t     ex_alu_op,
    output v_arch_pkg::sew_t       ex_sew,
    output v_arch_pkg::vreg_t      ex_op_a,
    output v_arch_pkg::vreg_t      ex_op_b,
    output logic                   wb_en,
    output v_arch_pkg::vreg_addr_t wb_addr,
    output v_arch_pkg::vreg_t      wb_data,
    output logic                   dm_v_write,
    output logic                   is_vltype,
    output v_arch_pkg::dmem_addr_t data_addr,
    output v_arch_pkg::vreg_t      v_store_data
);

    localparam int NBYTES = v_arch_pkg::VLEN / 8;

    v_isa_pkg::unit_t       ex_unit;
    v_arch_pkg::vl_t        ex_vl;
    v_arch_pkg::vreg_t      ex_old_vd;
    v_arch_pkg::dmem_addr_t ex_mem_addr;
    v_arch_pkg::vreg_t      new_data;
    logic [NBYTES-1:0]      byte_en;

    ////////////////////////////////////////////////////////////
    // stage 2 register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_unit <= v_isa_pkg::UNIT_NONE;
        end else begin
            ex_unit <= unit;    // bubbles arrive as UNIT_NONE
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_op   <= alu_op;
        ex_sew      <= vsew;
        ex_vl       <= vl;
        wb_addr     <= vd;
        ex_op_a     <= op_a;
        ex_op_b     <= op_b;
        ex_old_vd   <= old_vd;
        ex_mem_addr <= mem_addr;
    end

    ////////////////////////////////////////////////////////////
    // tail merge
    ////////////////////////////////////////////////////////////
    assign new_data = (ex_unit == v_isa_pkg::UNIT_LOAD) ? v_load_data : alu_result;

    always_comb begin
        for (int i = 0; i < NBYTES; i++) begin
            byte_en[i] = (i >> ex_sew) < int'(ex_vl);    // element index below vl
            wb_data[i*8 +: 8] = byte_en[i] ? new_data[i*8 +: 8] : ex_old_vd[i*8 +: 8];
        end
    end

    assign wb_en = (ex_unit == v_isa_pkg::UNIT_ALU) || (ex_unit == v_isa_pkg::UNIT_LOAD);

    // memory port
    assign dm_v_write   = (ex_unit == v_isa_pkg::UNIT_STORE);
    assign is_vltype    = (ex_unit == v_isa_pkg::UNIT_LOAD);
    assign data_addr    = ex_mem_addr;
    assign v_store_data = ex_old_vd;    // whole register, vl ignored

endmodule

`default_nettype wire

/* carrd_integrated.sv */
`timescale 1ns/1ps
`default_nettype none

module carrd_integrated (
    input  logic                   clk,
    input  logic                   reset,
    input  v_arch_pkg::word_t      op_instr_base,
    input  v_arch_pkg::word_t      xreg_out,
    input  v_arch_pkg::vreg_t      v_load_data,
    output v_arch_pkg::xreg_addr_t v_rd_xreg_addr,
    output logic                   dm_v_write,
    output logic                   is_vltype,
    output v_arch_pkg::dmem_addr_t data_addr,
    output v_arch_pkg::vreg_t      v_store_data
);

    // decode
    v_isa_pkg::unit_t       unit;
    v_isa_pkg::alu_op_t     alu_op;
    v_isa_pkg::src_sel_t    src_a_sel;
    logic                   is_vconfig;
    v_arch_pkg::vreg_addr_t vs1, vs2, vd;
    logic [4:0]             imm;
    v_arch_pkg::sew_t       zimm_sew;

    // csr
    v_arch_pkg::vl_t        vl;
    v_arch_pkg::sew_t       vsew;

    // stage 1 operands
    v_arch_pkg::vreg_t      rf_a, rf_b, rf_c;
    v_arch_pkg::vreg_t      op_a, op_b, old_vd;

    // stage 2
    v_isa_pkg::alu_op_t     ex_alu_op;
    v_arch_pkg::sew_t       ex_sew;
    v_arch_pkg::vreg_t      ex_op_a, ex_op_b, alu_result;
    logic                   wb_en;
    v_arch_pkg::vreg_addr_t wb_addr;
    v_arch_pkg::vreg_t      wb_data;

    v_decoder vdecoder (
        .instr(op_instr_base),
        .unit(unit),
        .alu_op(alu_op),
        .src_a_sel(src_a_sel),
        .is_vconfig(is_vconfig),
        .vs1(vs1),
        .vs2(vs2),
        .vd(vd),
        .imm(imm),
        .zimm_sew(zimm_sew),
        .rs1(v_rd_xreg_addr)
    );

    vcsr csr (
        .clk(clk),
        .reset(reset),
        .is_vconfig(is_vconfig),
        .avl(xreg_out),
        .new_sew(zimm_sew),
        .vl(vl),
        .vsew(vsew)
    );

    v_regfile vregfile (
        .clk(clk),
        .reset(reset),
        .rd_addr_a(vs1),
        .rd_addr_b(vs2),
        .rd_addr_c(vd),
        .wr_en(wb_en),
        .wr_addr(wb_addr),
        .wr_data(wb_data),
        .rd_data_a(rf_a),
        .rd_data_b(rf_b),
        .rd_data_c(rf_c)
    );

    v_operand_select opsel (
        .src_a_sel(src_a_sel),
        .vreg_a(rf_a),
        .vreg_b(rf_b),
        .vreg_old(rf_c),
        .vs1(vs1),
        .vs2(vs2),
        .vd(vd),
        .xreg(xreg_out),
        .imm(imm),
        .vsew(vsew),
        .wb_en(wb_en),
        .wb_addr(wb_addr),
        .wb_data(wb_data),
        .op_a(op_a),
        .op_b(op_b),
        .old_vd(old_vd)
    );

    v_lanes vlanes (
        .alu_op(ex_alu_op),
        .sew(ex_sew),
        .op_a(ex_op_a),
        .op_b(ex_op_b),
        .result(alu_result)
    );

    v_sequencer sequencer (
        .clk(clk),
        .reset(reset),
        .unit(unit),
        .alu_op(alu_op),
        .vsew(vsew),
        .vl(vl),
        .vd(vd),
        .op_a(op_a),
        .op_b(op_b),
        .old_vd(old_vd),
        .mem_addr(xreg_out[v_arch_pkg::DMEM_ADDR_LSB +: $bits(v_arch_pkg::dmem_addr_t)]),
        .alu_result(alu_result),
        .v_load_data(v_load_data),
        .ex_alu_op(ex_alu_op),
        .ex_sew(ex_sew),
        .ex_op_a(ex_op_a),
        .ex_op_b(ex_op_b),
        .wb_en(wb_en),
        .wb_addr(wb_addr),
        .wb_data(wb_data),
        .dm_v_write(dm_v_write),
        .is_vltype(is_vltype),
        .data_addr(data_addr),
        .v_store_data(v_store_data)
    );

endmodule

`default_nettype wire

/* carrd_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module carrd_checker (
    input  logic                   clk,
    input  logic                   reset,
    input  v_arch_pkg::word_t      op_instr_base,
    input  v_arch_pkg::xreg_addr_t v_rd_xreg_addr,
    input  logic                   dm_v_write,
    input  logic                   is_vltype,
    input  v_arch_pkg::dmem_addr_t data_addr,
    input  v_arch_pkg::vreg_t      v_store_data
);

    int errors  = 0;
    int checked = 0;
    int cyc     = 0;    // counts rising edges

    // expected memory accesses, oldest first
    logic                   exp_store [$];
    v_arch_pkg::dmem_addr_t exp_addr [$];
    v_arch_pkg::vreg_t      exp_data [$];
    int                     exp_due [$];

    task automatic expect_access(input logic store, input v_arch_pkg::dmem_addr_t addr,
                                 input v_arch_pkg::vreg_t data, input int due);
        exp_store.push_back(store);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_due.push_back(due);
    endtask

    function automatic int pending();
        return exp_due.size();
    endfunction

    task automatic report_value(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        errors++;
        $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
    endtask

    task automatic drop_front();
        exp_store.delete(0);
        exp_addr.delete(0);
        exp_data.delete(0);
        exp_due.delete(0);
    endtask

    ////////////////////////////////////////////////////////////
    // compare on every rising edge
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (!reset) begin
            if (v_rd_xreg_addr !== op_instr_base[19:15]) begin
                report_value("v_rd_xreg_addr", v_rd_xreg_addr, op_instr_base[19:15]);
            end
            if (dm_v_write === 1'b1 || is_vltype === 1'b1) begin
                if (exp_due.size() == 0) begin
                    errors++;
                    $display("Error at %0t ns: memory access with nothing outstanding", $time);
                end else begin
                    if (dm_v_write !== exp_store[0]) begin
                        report_value("dm_v_write", dm_v_write, exp_store[0]);
                    end
                    if (is_vltype !== !exp_store[0]) begin
                        report_value("is_vltype", is_vltype, !exp_store[0]);
                    end
                    if (data_addr !== exp_addr[0]) begin
                        report_value("data_addr", data_addr, exp_addr[0]);
                    end
                    if (exp_store[0] && v_store_data !== exp_data[0]) begin
                        report_value("v_store_data", v_store_data, exp_data[0]);
                    end
                    if (cyc != exp_due[0]) begin
                        errors++;
                        $display("Error at %0t ns: access due in cycle %0d came in cycle %0d",
                                 $time, exp_due[0], cyc);
                    end
                    checked++;
                    drop_front();
                end
            end else if (exp_due.size() > 0 && exp_due[0] <= cyc) begin
                errors++;
                $display("Error at %0t ns: expected %s at address %0h never came", $time,
                         exp_store[0] ? "store" : "load", exp_addr[0]);
                drop_front();
            end
        end
        cyc++;
    end

endmodule

`default_nettype wire

/* tb_carrd_integrated.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_carrd_integrated;

    localparam int DMEM_WORDS = 1024;

    logic                   clk = 1'b0;
    logic                   reset;
    v_arch_pkg::word_t      op_instr_base;
    v_arch_pkg::word_t      xreg_out;
    v_arch_pkg::vreg_t      v_load_data;
    v_arch_pkg::xreg_addr_t v_rd_xreg_addr;
    logic                   dm_v_write;
    logic                   is_vltype;
    v_arch_pkg::dmem_addr_t data_addr;
    v_arch_pkg::vreg_t      v_store_data;

    v_arch_pkg::vreg_t mem [DMEM_WORDS];          // seen by the DUT
    v_arch_pkg::vreg_t model_mem [DMEM_WORDS];
    v_arch_pkg::vreg_t mreg [32];                 // register file model
    int                mvl;
    int                msew;
    int                tb_errors    = 0;
    int                timeouts     = 0;
    int                failed_tests = 0;
    int                err_mark     = 0;

    always #4 clk = ~clk;

    carrd_integrated UUT (
        .clk(clk),
        .reset(reset),
        .op_instr_base(op_instr_base),
        .xreg_out(xreg_out),
        .v_load_data(v_load_data),
        .v_rd_xreg_addr(v_rd_xreg_addr),
        .dm_v_write(dm_v_write),
        .is_vltype(is_vltype),
        .data_addr(data_addr),
        .v_store_data(v_store_data)
    );

    carrd_checker chk (
        .clk(clk),
        .reset(reset),
        .op_instr_base(op_instr_base),
        .v_rd_xreg_addr(v_rd_xreg_addr),
        .dm_v_write(dm_v_write),
        .is_vltype(is_vltype),
        .data_addr(data_addr),
        .v_store_data(v_store_data)
    );

    assign v_load_data = mem[data_addr];    // asynchronous read

    always @(posedge clk) begin
        if (dm_v_write) begin
            mem[data_addr] <= v_store_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // encoders
    ////////////////////////////////////////////////////////////
    function automatic v_arch_pkg::word_t encode_arith(input logic [5:0] f6, input logic [2:0] f3,
                                                       input int vs2, input int src, input int vd);
        return {f6, 1'b1, 5'(vs2), 5'(src), f3, 5'(vd), v_isa_pkg::OPC_OP_V};
    endfunction

    function automatic v_arch_pkg::word_t encode_vsetvli(input int sew, input int rs1);
        return {6'b0, 3'(sew), 3'b0, 5'(rs1), v_isa_pkg::F3_OPCFG, 5'd0, v_isa_pkg::OPC_OP_V};
    endfunction

    function automatic v_arch_pkg::word_t encode_mem(input logic [6:0] opc, input int vd,
                                                     input int rs1);
        int w;
        w = $urandom % 3;
        return {6'b0, 1'b1, 5'b0, 5'(rs1), (w == 0) ? 3'b000 : (w == 1) ? 3'b101 : 3'b110,
                5'(vd), opc};
    endfunction

    function automatic logic [5:0] funct6_of(input int op);
        case (op)
            0: return v_isa_pkg::F6_VADD;
            1: return v_isa_pkg::F6_VSUB;
            2: return v_isa_pkg::F6_VAND;
            3: return v_isa_pkg::F6_VOR;
            4: return v_isa_pkg::F6_VXOR;
            5: return v_isa_pkg::F6_VSLL;
            default: return v_isa_pkg::F6_VSRL;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // model
    ////////////////////////////////////////////////////////////
    function automatic v_arch_pkg::vreg_t fill_word(input int a);
        return {32'(a) * 32'h9e3779b1, 32'(a) ^ 32'h5a5a0f0f, ~32'(a) * 32'h85ebca6b,
                32'(a) + 32'hc2b2ae35};
    endfunction

    function automatic v_arch_pkg::word_t addr_word(input int addr);
        return ($urandom & 32'hffffc00f) | (32'(addr) << 4);    // junk outside 13:4
    endfunction

    function automatic v_arch_pkg::vreg_t splat(input logic [31:0] v);
        v_arch_pkg::vreg_t r;
        int ew;
        ew = 8 << msew;
        for (int j = 0; j < 128; j++) r[j] = v[j % ew];
        return r;
    endfunction

    // elements below vl from nv, tail from old
    function automatic v_arch_pkg::vreg_t merge(input v_arch_pkg::vreg_t nv,
                                                input v_arch_pkg::vreg_t old);
        v_arch_pkg::vreg_t r;
        int ew;
        ew = 8 << msew;
        for (int j = 0; j < 128; j++) r[j] = (j / ew < mvl) ? nv[j] : old[j];
        return r;
    endfunction

    function automatic v_arch_pkg::vreg_t alu_model(input int op, input v_arch_pkg::vreg_t a,
                                                    input v_arch_pkg::vreg_t b);
        v_arch_pkg::vreg_t r;
        longint ea;
        longint eb;
        longint er;
        longint mask;
        int ew;
        ew = 8 << msew;
        mask = (64'd1 << ew) - 1;
        r = '0;
        for (int e = 0; e < 128 / ew; e++) begin
            ea = (a >> (e * ew)) & mask;
            eb = (b >> (e * ew)) & mask;
            case (op)
                0: er = eb + ea;
                1: er = eb - ea;
                2: er = eb & ea;
                3: er = eb | ea;
                4: er = eb ^ ea;
                5: er = eb << (ea % ew);
                default: er = eb >> (ea % ew);
            endcase
            r |= v_arch_pkg::vreg_t'(er & mask) << (e * ew);
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // issue, one word per falling edge
    ////////////////////////////////////////////////////////////
    task automatic drive(input v_arch_pkg::word_t instr, input v_arch_pkg::word_t xval);
        @(negedge clk);
        op_instr_base = instr;
        xreg_out = xval;
    endtask

    task automatic set_vtype(input int sew, input int avl);
        drive(encode_vsetvli(sew, $urandom % 32), avl);
        if (sew <= 2) begin    // reserved widths change nothing
            msew = sew;
            mvl = (avl < (16 >> sew)) ? avl : (16 >> sew);
        end
    endtask

    task automatic issue_alu(input int op, input int form, input int vs2, input int src,
                             input int vd, input v_arch_pkg::word_t xval);
        v_arch_pkg::vreg_t a;
        logic [2:0] f3;
        case (form)
            0: begin
                a = mreg[src];
                f3 = v_isa_pkg::F3_OPIVV;
            end
            1: begin
                a = splat(xval);
                f3 = v_isa_pkg::F3_OPIVX;
            end
            default: begin
                a = splat(src);    // zero-extended imm
                f3 = v_isa_pkg::F3_OPIVI;
            end
        endcase
        drive(encode_arith(funct6_of(op), f3, vs2, src, vd), xval);
        mreg[vd] = merge(alu_model(op, a, mreg[vs2]), mreg[vd]);
    endtask

    task automatic rand_arith(input int vs2, input int src, input int vd);
        int op;
        int form;
        op = $urandom % 7;
        form = $urandom % 3;
        if (op == 1 && form == 2) form = 0;    // no vsub.vi
        issue_alu(op, form, vs2, src, vd, $urandom);
    endtask

    task automatic load_vreg(input int vd, input int addr);
        drive(encode_mem(v_isa_pkg::OPC_LOAD_FP, vd, $urandom % 32), addr_word(addr));
        chk.expect_access(1'b0, addr, '0, chk.cyc + 1);
        mreg[vd] = merge(model_mem[addr], mreg[vd]);
    endtask

    task automatic store_vreg(input int vd, input int addr);
        drive(encode_mem(v_isa_pkg::OPC_STORE_FP, vd, $urandom % 32), addr_word(addr));
        chk.expect_access(1'b1, addr, mreg[vd], chk.cyc + 1);
        model_mem[addr] = mreg[vd];
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        drive('0, '0);
        while (chk.pending() > 0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (chk.pending() > 0) begin
            timeouts++;
            $display("Timeout at %0t ns: %0d memory accesses still outstanding", $time,
                     chk.pending());
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        drain();
        errs = chk.errors + tb_errors + timeouts - err_mark;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: FAILED with %0d errors", name, errs);
        end
        err_mark = chk.errors + tb_errors + timeouts;
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////
    initial begin
        int seed;
        int r;
        int q;
        int s;
        int total;
        seed = $urandom(32'h8ca8);
        reset = 1'b1;
        op_instr_base = '0;
        xreg_out = '0;
        mvl = 0;
        msew = 0;
        for (int i = 0; i < 32; i++) mreg[i] = '0;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            mem[i] = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        repeat (3) @(negedge clk);
        reset = 1'b0;

        if (dm_v_write !== 1'b0 || is_vltype !== 1'b0) begin
            tb_errors++;
            $display("Error at %0t ns: memory port active right after reset", $time);
        end
        for (int i = 0; i < 6; i++) store_vreg($urandom % 32, $urandom % DMEM_WORDS);
        end_test("reset_state");

        // short loads keep the tail of a full one
        for (int i = 0; i < 12; i++) begin
            s = i % 3;
            r = $urandom % 32;
            set_vtype(s, 64);
            load_vreg(r, $urandom % DMEM_WORDS);
            set_vtype(s, (i < 6) ? $urandom % (16 >> s) : 16 + $urandom % 24);
            load_vreg(r, $urandom % DMEM_WORDS);
            store_vreg(r, $urandom % DMEM_WORDS);
        end
        end_test("vsetvli_tail");

        set_vtype(2, 4);
        for (int i = 0; i < 32; i++) load_vreg(i, $urandom % DMEM_WORDS);
        for (int i = 0; i < 60; i++) begin
            if (i % 6 == 0) set_vtype($urandom % 3, $urandom % 20);
            r = $urandom % 32;
            rand_arith($urandom % 32, $urandom % 32, r);
            if (i % 2) drive('0, '0);
            store_vreg(r, $urandom % DMEM_WORDS);
        end
        end_test("random_alu");

        for (int i = 0; i < 20; i++) begin
            if (i % 5 == 0) set_vtype($urandom % 3, $urandom % 20);
            r = $urandom % 32;
            q = $urandom % 32;
            rand_arith($urandom % 32, $urandom % 32, r);
            rand_arith(r, r, q);
            store_vreg(q, $urandom % DMEM_WORDS);
            load_vreg(r, $urandom % DMEM_WORDS);
            rand_arith(r, $urandom % 32, r);
            store_vreg(r, $urandom % DMEM_WORDS);
        end
        end_test("back_to_back");

        for (int i = 0; i < 60; i++) begin
            r = $urandom % 32;
            case ($urandom % 9)
                0: drive('0, $urandom);
                1: drive(encode_arith(v_isa_pkg::F6_VSUB, v_isa_pkg::F3_OPIVI, r, r, r), $urandom);
                2: drive(encode_arith(6'b111111, v_isa_pkg::F3_OPIVV, r, r, r), $urandom);
                3: drive(encode_mem(v_isa_pkg::OPC_LOAD_FP, r, r) | 32'h0800_0000, $urandom);
                4: drive(encode_mem(v_isa_pkg::OPC_STORE_FP, r, r) | 32'he000_0000, $urandom);
                5: drive(($urandom & ~32'h7f) | 32'h33, $urandom);    // scalar OP
                6: set_vtype(3 + $urandom % 5, $urandom % 20);
                7: drive(encode_vsetvli(1, r) | 32'h8000_0000, $urandom);    // vsetvl
                default: rand_arith($urandom % 32, $urandom % 32, r);
            endcase
        end
        for (int i = 0; i < 32; i++) store_vreg(i, i);
        end_test("illegal_mix");

        total = chk.errors + tb_errors + timeouts;
        $display("tests 5, failed %0d, accesses checked %0d, errors %0d", failed_tests,
                 chk.checked, total);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* carrd_integrated.f */
v_arch_pkg.sv
v_isa_pkg.sv
v_decoder.sv
vcsr.sv
v_regfile.sv
v_operand_select.sv
v_lanes.sv
v_sequencer.sv
carrd_integrated.sv
carrd_checker.sv
tb_carrd_integrated.sv

/* Bender.yml */
package:
  name: carrd_integrated

sources:
  - files:
      - v_arch_pkg.sv
      - v_isa_pkg.sv
      - v_decoder.sv
      - vcsr.sv
      - v_regfile.sv
      - v_operand_select.sv
      - v_lanes.sv
      - v_sequencer.sv
      - carrd_integrated.sv
  - target: test
    files:
      - carrd_checker.sv
      - tb_carrd_integrated.sv
